// ==== fe_cfg_pkg.sv ====
// front end configuration constants.
// address, stack, tag and instruction widths plus boot address.

package fe_cfg_pkg;

  ////////////////////////////////////////
  // address space
  ////////////////////////////////////////

  localparam int vaddr_width_lp = 32;              // every pc is this wide.
  localparam int instr_width_lp = 32;              // one uncompressed word.

  localparam logic [vaddr_width_lp-1:0] boot_pc_lp = 32'h8000_0000; // first fetch.

  ////////////////////////////////////////
  // return address stack
  ////////////////////////////////////////

  localparam int ras_idx_width_lp   = 3;                       // top pointer width.
  localparam int ras_num_entries_lp = 1 << ras_idx_width_lp;   // 8 entries.

  ////////////////////////////////////////
  // instruction tags / checkpoints
  ////////////////////////////////////////

  localparam int tag_width_lp = 4;                   // tag per accepted word.
  localparam int num_tags_lp  = 1 << tag_width_lp;   // one checkpoint slot per tag.

endpackage : fe_cfg_pkg

// ==== fe_types_pkg.sv ====
// instruction class enum, predecode result struct and
// the RISC-V encodings the predecoder looks at.

package fe_types_pkg;

  import fe_cfg_pkg::*;

  ////////////////////////////////////////
  // rv32 encodings
  ////////////////////////////////////////

  localparam logic [6:0] opcode_jal_lp   = 7'b1101111;  // jal.
  localparam logic [6:0] opcode_jalr_lp  = 7'b1100111;  // jalr.
  localparam logic [2:0] funct3_jalr_lp  = 3'b000;      // only legal jalr funct3.

  localparam logic [4:0] reg_x0_lp = 5'd0;   // zero register.
  localparam logic [4:0] reg_ra_lp = 5'd1;   // x1, ra.
  localparam logic [4:0] reg_t0_lp = 5'd5;   // x5, alternate link.

  ////////////////////////////////////////
  // predecode output
  ////////////////////////////////////////

  typedef enum logic [1:0]
  {
    e_cls_other  = 2'b00,   // runs on as pc plus 4.
    e_cls_call   = 2'b01,   // jal with link rd.
    e_cls_return = 2'b10    // jalr x0, link rs1.
  } instr_class_e;

  typedef struct packed
  {
    instr_class_e              instr_class;  // what kind of control transfer.
    logic [vaddr_width_lp-1:0] jal_target;   // pc plus j-immediate.
    logic [vaddr_width_lp-1:0] link_addr;    // pc plus 4.
  } predecode_s;

endpackage : fe_types_pkg

// ==== fe_ras_if.sv ====
// push, pop and checkpoint signals between pc generator and stack.

`timescale 1ns/1ps

interface fe_ras_if
  import fe_cfg_pkg::*;
  ();

  logic                        push_en;      // push at next edge.
  logic [vaddr_width_lp-1:0]   push_pc;      // return address to push.
  logic                        pop_en;       // pop at next edge.
  logic [vaddr_width_lp-1:0]   pop_pc;       // top entry, combinational.
  logic [ras_idx_width_lp-1:0] ckpt_ptr;     // current top pointer.
  logic                        restore_v;    // load pointer, beats push/pop.
  logic [ras_idx_width_lp-1:0] restore_ptr;  // pointer to load.

  // pc generator side.
  modport pcgen_mp
  (
    output push_en, push_pc, pop_en, restore_v, restore_ptr,
    input  pop_pc, ckpt_ptr
  );

  // stack side.
  modport ras_mp
  (
    input  push_en, push_pc, pop_en, restore_v, restore_ptr,
    output pop_pc, ckpt_ptr
  );

endinterface : fe_ras_if

// ==== fe_predecode.sv ====
// call / return predecoder.
// computes jal target and link address for the fetched word.

`timescale 1ns/1ps

module fe_predecode
  import fe_cfg_pkg::*;
  import fe_types_pkg::*;
(
  input  logic [instr_width_lp-1:0] instr_i,   // fetched word.
  input  logic [vaddr_width_lp-1:0] pc_i,      // its address.
  output predecode_s                decode_o   // class and addresses.
);

  ////////////////////////////////////////
  // field extraction
  ////////////////////////////////////////

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [2:0] funct3;

  assign opcode = instr_i[6:0];    // major opcode.
  assign rd     = instr_i[11:7];   // destination.
  assign funct3 = instr_i[14:12];  // jalr needs 000.
  assign rs1    = instr_i[19:15];  // jalr base.

  logic is_jal;
  logic is_jalr;
  logic rd_is_link;
  logic rs1_is_link;

  assign is_jal      = (opcode == opcode_jal_lp);
  assign is_jalr     = (opcode == opcode_jalr_lp) && (funct3 == funct3_jalr_lp);
  assign rd_is_link  = (rd == reg_ra_lp) || (rd == reg_t0_lp);    // x1 or x5.
  assign rs1_is_link = (rs1 == reg_ra_lp) || (rs1 == reg_t0_lp);  // x1 or x5.

  ////////////////////////////////////////
  // j-immediate and addresses
  ////////////////////////////////////////

  // imm[20|10:1|11|19:12] scattered over bits 31:12, sign from bit 31.
  logic [vaddr_width_lp-1:0] jal_imm;

  assign jal_imm = {{(vaddr_width_lp-20){instr_i[31]}},  // sign extension.
                    instr_i[19:12],                      // imm[19:12].
                    instr_i[20],                         // imm[11].
                    instr_i[30:21],                      // imm[10:1].
                    1'b0};                               // halfword aligned.

  assign decode_o.jal_target = pc_i + jal_imm;                      // pc relative.
  assign decode_o.link_addr  = pc_i + vaddr_width_lp'(4);           // next word.

  ////////////////////////////////////////
  // classification
  ////////////////////////////////////////

  always_comb
  begin
    decode_o.instr_class = e_cls_other;             // default, fall through.
    if (is_jal && rd_is_link)
    begin
      decode_o.instr_class = e_cls_call;            // jal ra / jal t0.
    end
    else if (is_jalr && rs1_is_link && (rd == reg_x0_lp))
    begin
      decode_o.instr_class = e_cls_return;          // ret form only.
    end
  end

endmodule : fe_predecode

// ==== fe_ras.sv ====
// return address stack.
// circular top pointer with checkpoint restore.

`timescale 1ns/1ps

module fe_ras
  import fe_cfg_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  fe_ras_if.ras_mp ras              // push / pop / restore port.
);

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////

  logic [ras_idx_width_lp-1:0] top_ptr_r;   // points at topmost valid entry.
  logic [ras_idx_width_lp-1:0] top_ptr_n;   // next pointer value.
  logic [ras_idx_width_lp-1:0] push_idx;    // slot above the top.

  logic [ras_num_entries_lp-1:0][vaddr_width_lp-1:0] ras_entries;  // stack storage.

  assign push_idx = top_ptr_r + 1'b1;       // wraps past the last entry.

  // reads come straight off the top, no bypass of a same-cycle push.
  assign ras.pop_pc   = ras_entries[top_ptr_r];
  assign ras.ckpt_ptr = top_ptr_r;          // snapshot for the checkpoint table.

  ////////////////////////////////////////
  // pointer update
  ////////////////////////////////////////

  always_comb
  begin
    if (ras.restore_v)
    begin
      top_ptr_n = ras.restore_ptr;          // misprediction recovery.
    end
    else if (ras.push_en)
    begin
      top_ptr_n = push_idx;                 // overflow wraps.
    end
    else if (ras.pop_en)
    begin
      top_ptr_n = top_ptr_r - 1'b1;         // underflow wraps too.
    end
    else
    begin
      top_ptr_n = top_ptr_r;                // hold.
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      top_ptr_r   <= '0;                    // first push lands in entry 1.
      ras_entries <= '0;
    end
    else
    begin
      top_ptr_r <= top_ptr_n;
      if (ras.push_en && !ras.restore_v)
      begin
        ras_entries[push_idx] <= ras.push_pc;  // oldest entry overwritten on overflow.
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // the pc generator only ever sees one class per accepted word.
  push_pop_excl_a : assert property (@(posedge clk_i) disable iff (reset_i)
    !(ras.push_en && ras.pop_en))
    else $error("ras push and pop asserted together");

endmodule : fe_ras

// ==== fe_ckpt_table.sv ====
// checkpoint table of stack top pointers.
// one slot per tag, combinational read.

`timescale 1ns/1ps

module fe_ckpt_table
  import fe_cfg_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        wr_en_i,    // instruction accepted.
  input  logic [tag_width_lp-1:0]     wr_tag_i,   // its tag.
  input  logic [ras_idx_width_lp-1:0] wr_ptr_i,   // pointer before it.
  input  logic [tag_width_lp-1:0]     rd_tag_i,   // redirect tag.
  output logic [ras_idx_width_lp-1:0] rd_ptr_o    // pointer to restore.
);

  logic [ras_idx_width_lp-1:0] ptr_mem_r [num_tags_lp];  // one pointer per tag.

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < num_tags_lp; i++)
      begin
        ptr_mem_r[i] <= '0;                 // all slots point at the empty stack.
      end
    end
    else if (wr_en_i)
    begin
      ptr_mem_r[wr_tag_i] <= wr_ptr_i;      // slot reused once tags wrap.
    end
  end

  assign rd_ptr_o = ptr_mem_r[rd_tag_i];    // same-cycle restore.

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // tag counter in the pc generator must be out of reset and defined.
  wr_tag_known_a : assert property (@(posedge clk_i) disable iff (reset_i)
    wr_en_i |-> !$isunknown(wr_tag_i))
    else $error("checkpoint write with unknown tag");

endmodule : fe_ckpt_table

// ==== fe_pc_gen.sv ====
// pc register, next-pc select and tag counter.
// drives stack push/pop/restore and checkpoint writes.

`timescale 1ns/1ps

module fe_pc_gen
  import fe_cfg_pkg::*;
  import fe_types_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        instr_v_i,       // word for pc_o is valid.
  input  logic [instr_width_lp-1:0]   instr_i,
  input  logic                        redirect_v_i,    // back end redirect.
  input  logic [tag_width_lp-1:0]     redirect_tag_i,
  input  logic [vaddr_width_lp-1:0]   redirect_pc_i,
  input  logic [ras_idx_width_lp-1:0] ckpt_ptr_i,      // read back from table.
  output logic [vaddr_width_lp-1:0]   pc_o,
  output logic [tag_width_lp-1:0]     tag_o,
  output logic                        ckpt_wr_en_o,
  output logic [tag_width_lp-1:0]     ckpt_wr_tag_o,
  output logic [ras_idx_width_lp-1:0] ckpt_wr_ptr_o,
  output logic [tag_width_lp-1:0]     ckpt_rd_tag_o,
  fe_ras_if.pcgen_mp                  ras             // stack control.
);

  logic [vaddr_width_lp-1:0] pc_r;      // current fetch address.
  logic [vaddr_width_lp-1:0] pc_n;
  logic [tag_width_lp-1:0]   tag_r;     // tag for the word at pc_r.
  logic                      accept;    // word taken this cycle.
  predecode_s                decode;

  fe_predecode predecode
  (
    .instr_i  (instr_i),
    .pc_i     (pc_r),
    .decode_o (decode)
  );

  assign accept = instr_v_i && !redirect_v_i;   // redirect drops the word.

  ////////////////////////////////////////
  // next pc
  ////////////////////////////////////////

  always_comb
  begin
    if (redirect_v_i)
      pc_n = redirect_pc_i;
    else if (!accept)
      pc_n = pc_r;                              // no word, hold.
    else if (decode.instr_class == e_cls_call)
      pc_n = decode.jal_target;
    else if (decode.instr_class == e_cls_return)
      pc_n = ras.pop_pc;                        // top before the pop.
    else
      pc_n = decode.link_addr;                  // sequential.
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r  <= boot_pc_lp;
      tag_r <= '0;
    end
    else
    begin
      pc_r <= pc_n;
      if (accept)
        tag_r <= tag_r + 1'b1;                  // wraps after 15.
    end
  end

  assign pc_o  = pc_r;
  assign tag_o = tag_r;

  ////////////////////////////////////////
  // stack and checkpoint control
  ////////////////////////////////////////

  assign ras.push_en     = accept && (decode.instr_class == e_cls_call);
  assign ras.push_pc     = decode.link_addr;        // return lands after the jal.
  assign ras.pop_en      = accept && (decode.instr_class == e_cls_return);
  assign ras.restore_v   = redirect_v_i;
  assign ras.restore_ptr = ckpt_ptr_i;              // pointer before the tagged word.

  assign ckpt_wr_en_o  = accept;                    // every accepted word checkpoints.
  assign ckpt_wr_tag_o = tag_r;
  assign ckpt_wr_ptr_o = ras.ckpt_ptr;              // pointer before this word.
  assign ckpt_rd_tag_o = redirect_tag_i;

  // targets come from predecode, the stack or the back end.
  pc_aligned_a : assert property (@(posedge clk_i) disable iff (reset_i)
    pc_r[1:0] == 2'b00)
    else $error("fetch pc not word aligned");

endmodule : fe_pc_gen

// ==== fe_ras_top.sv ====
// fetch return-prediction top.
// pc generator, return address stack and checkpoint table.

`timescale 1ns/1ps

module fe_ras_top
  import fe_cfg_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      instr_v_i,
  input  logic [instr_width_lp-1:0] instr_i,
  input  logic                      redirect_v_i,
  input  logic [tag_width_lp-1:0]   redirect_tag_i,
  input  logic [vaddr_width_lp-1:0] redirect_pc_i,
  output logic [vaddr_width_lp-1:0] pc_o,
  output logic [tag_width_lp-1:0]   tag_o
);

  fe_ras_if ras_if ();                          // pc gen <-> stack.

  logic                        ckpt_wr_en;
  logic [tag_width_lp-1:0]     ckpt_wr_tag;
  logic [ras_idx_width_lp-1:0] ckpt_wr_ptr;
  logic [tag_width_lp-1:0]     ckpt_rd_tag;
  logic [ras_idx_width_lp-1:0] ckpt_rd_ptr;

  fe_pc_gen pc_gen
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_v_i      (instr_v_i),
    .instr_i        (instr_i),
    .redirect_v_i   (redirect_v_i),
    .redirect_tag_i (redirect_tag_i),
    .redirect_pc_i  (redirect_pc_i),
    .ckpt_ptr_i     (ckpt_rd_ptr),
    .pc_o           (pc_o),
    .tag_o          (tag_o),
    .ckpt_wr_en_o   (ckpt_wr_en),
    .ckpt_wr_tag_o  (ckpt_wr_tag),
    .ckpt_wr_ptr_o  (ckpt_wr_ptr),
    .ckpt_rd_tag_o  (ckpt_rd_tag),
    .ras            (ras_if.pcgen_mp)
  );

  fe_ras ras
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ras     (ras_if.ras_mp)
  );

  fe_ckpt_table ckpt_table
  (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wr_en_i  (ckpt_wr_en),
    .wr_tag_i (ckpt_wr_tag),
    .wr_ptr_i (ckpt_wr_ptr),
    .rd_tag_i (ckpt_rd_tag),
    .rd_ptr_o (ckpt_rd_ptr)
  );

endmodule : fe_ras_top

// ==== tb_fe_ras_top.sv ====
// testbench for the fetch return-prediction top.
// table of stimulus rows with expected pc and tag, applied once per cycle.

`timescale 1ns/1ps

module tb_fe_ras_top;

  import fe_cfg_pkg::*;
  import fe_types_pkg::*;

  logic                      clk_i;
  logic                      reset_i;
  logic                      instr_v_i;
  logic [instr_width_lp-1:0] instr_i;
  logic                      redirect_v_i;
  logic [tag_width_lp-1:0]   redirect_tag_i;
  logic [vaddr_width_lp-1:0] redirect_pc_i;
  logic [vaddr_width_lp-1:0] pc_o;
  logic [tag_width_lp-1:0]   tag_o;

  typedef struct packed
  {
    logic                      redir_v;
    logic [tag_width_lp-1:0]   redir_tag;
    logic [vaddr_width_lp-1:0] redir_pc;
    logic                      instr_v;
    logic [instr_width_lp-1:0] instr;
    logic [vaddr_width_lp-1:0] exp_pc;    // pc_o after the edge.
    logic [tag_width_lp-1:0]   exp_tag;   // tag_o after the edge.
  } stim_row_s;

  stim_row_s                 rows [$];    // whole stimulus table.
  logic [vaddr_width_lp-1:0] model_pc;    // expected fetch address.
  logic [tag_width_lp-1:0]   model_tag;   // expected next tag.
  int                        error_count;
  int                        check_count;

  fe_ras_top uut
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_v_i      (instr_v_i),
    .instr_i        (instr_i),
    .redirect_v_i   (redirect_v_i),
    .redirect_tag_i (redirect_tag_i),
    .redirect_pc_i  (redirect_pc_i),
    .pc_o           (pc_o),
    .tag_o          (tag_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;             // 100 ns period.
  end

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
    end
  endtask

  ////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [31:0] offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'h000, rs1, 3'b000, rd, 7'b1100111};    // zero offset.
  endfunction

  function automatic logic [31:0] filler_word();
    logic [31:0] r;
    r = $urandom;
    return {r[31:7], 7'b0010011};                     // op-imm opcode is never a jump.
  endfunction

  ////////////////////////////////////////
  // table building
  ////////////////////////////////////////

  // appends one row and advances the expected pc and tag.
  task automatic add_row(input logic redir_v, input logic [tag_width_lp-1:0] redir_tag,
                         input logic [31:0] redir_pc, input logic instr_v,
                         input logic [31:0] instr, input logic [31:0] next_pc);
    stim_row_s row;
    row.redir_v   = redir_v;
    row.redir_tag = redir_tag;
    row.redir_pc  = redir_pc;
    row.instr_v   = instr_v;
    row.instr     = instr;
    if (redir_v)
      model_pc = redir_pc;                            // word dropped, tag kept.
    else if (instr_v)
    begin
      model_pc  = next_pc;
      model_tag = model_tag + tag_width_lp'(1);       // wraps after 15.
    end
    row.exp_pc  = model_pc;
    row.exp_tag = model_tag;
    rows.push_back(row);
  endtask

  task automatic add_filler(input int count);
    for (int k = 0; k < count; k++)
      add_row(1'b0, '0, '0, 1'b1, filler_word(), model_pc + 32'd4);
  endtask

  task automatic add_idle(input int count);
    for (int k = 0; k < count; k++)
      add_row(1'b0, '0, '0, 1'b0, filler_word(), model_pc);   // holds state.
  endtask

  task automatic add_call(input logic [4:0] rd, input logic [31:0] offset,
                          output logic [31:0] link);
    link = model_pc + 32'd4;
    add_row(1'b0, '0, '0, 1'b1, jal_word(rd, offset), model_pc + offset);
  endtask

  task automatic add_return(input logic [4:0] rs1, input logic [31:0] target);
    add_row(1'b0, '0, '0, 1'b1, jalr_word(5'd0, rs1), target);
  endtask

  task automatic build_table();
    logic [31:0]             links [9];
    logic [31:0]             l1, l2, l3, la, lb, lc, ld;
    logic [tag_width_lp-1:0] tag_b, tag_f;
    model_pc  = boot_pc_lp;
    model_tag = '0;
    // sequential run, tag wrap, idle hold.
    add_filler(10);
    add_idle(3);
    add_filler(8);
    // nested calls and returns in reverse order.
    add_call(5'd1, 32'h0000_0100, l1);
    add_call(5'd1, 32'h0000_0200, l2);
    add_call(5'd5, -32'sd64, l3);                     // backward target.
    add_return(5'd1, l3);
    add_return(5'd5, l2);
    add_return(5'd1, l1);
    add_row(1'b0, '0, '0, 1'b1, jalr_word(5'd0, 5'd2), model_pc + 32'd4);  // not predicted.
    // ninth push of the overflow run overwrites the oldest entry.
    for (int k = 0; k < 9; k++)
      add_call(5'd1, 32'(k + 1) * 32'h40, links[k]);
    for (int k = 8; k >= 1; k--)
      add_return(5'd1, links[k]);
    add_return(5'd1, links[8]);
    // redirect restores the pointer from before call b.
    add_call(5'd1, 32'h0000_0300, la);
    tag_b = model_tag;
    add_call(5'd1, 32'h0000_0100, lb);
    add_call(5'd5, 32'h0000_0100, lc);
    add_filler(1);
    add_row(1'b1, tag_b, 32'h8000_4000, 1'b0, '0, '0);
    add_filler(2);
    add_return(5'd1, la);
    // redirect beats a valid call in the same cycle.
    add_call(5'd1, 32'h0000_0080, ld);
    tag_f = model_tag;
    add_filler(1);
    add_row(1'b1, tag_f, 32'h8000_8000, 1'b1, jal_word(5'd1, 32'h200), '0);
    add_return(5'd1, ld);
  endtask

  ////////////////////////////////////////
  // driving
  ////////////////////////////////////////

  task automatic drive_row(input stim_row_s row);
    redirect_v_i   <= row.redir_v;
    redirect_tag_i <= row.redir_tag;
    redirect_pc_i  <= row.redir_pc;
    instr_v_i      <= row.instr_v;
    instr_i        <= row.instr;
  endtask

  task automatic wait_reset_release(output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < 20 && !ok; cycles++)
    begin
      @(negedge clk_i);
      ok = (reset_i === 1'b0) && !$isunknown({pc_o, tag_o});
    end
    if (!ok)
      $display("timeout: DUT outputs not defined after reset within %0d cycles", cycles);
  endtask

  // row i is driven at one edge, sampled at the next, checked at the negedge after.
  task automatic run_table();
    @(posedge clk_i);
    drive_row(rows[0]);
    for (int i = 0; i < rows.size(); i++)
    begin
      @(posedge clk_i);
      if (i + 1 < rows.size())
        drive_row(rows[i + 1]);
      else
        drive_row('0);                              // idle after the last row.
      @(negedge clk_i);
      check_value($sformatf("row %0d pc_o", i), pc_o, rows[i].exp_pc);
      check_value($sformatf("row %0d tag_o", i), 32'(tag_o), 32'(rows[i].exp_tag));
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    bit reset_ok;
    void'($urandom(19));
    error_count    = 0;
    check_count    = 0;
    reset_i        = 1'b1;
    instr_v_i      = 1'b0;
    instr_i        = '0;
    redirect_v_i   = 1'b0;
    redirect_tag_i = '0;
    redirect_pc_i  = '0;
    build_table();
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    wait_reset_release(reset_ok);
    if (reset_ok)
    begin
      check_value("pc_o after reset", pc_o, boot_pc_lp);
      check_value("tag_o after reset", 32'(tag_o), 32'd0);
      run_table();
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (!reset_ok || error_count != 0)
      $display("SOME TESTS FAILED");
    else
      $display("ALL TESTS PASSED");
    $finish;
  end

endmodule : tb_fe_ras_top

// ==== compile.f ====
fe_cfg_pkg.sv
fe_types_pkg.sv
fe_ras_if.sv
fe_predecode.sv
fe_ras.sv
fe_ckpt_table.sv
fe_pc_gen.sv
fe_ras_top.sv
tb_fe_ras_top.sv

// ==== Makefile ====
# Verilator simulation of the fetch return-prediction block.

VERILATOR ?= verilator
TOP       ?= tb_fe_ras_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
